/* hw/rename_settings.svh */
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// register counts
////////////////////////////////////////////////////////////////////////////

`define ARCH_REGS 32   // architectural registers seen by the front end
`define PHYS_REGS 64   // physical registers behind the map

////////////////////////////////////////////////////////////////////////////
// queue depths
////////////////////////////////////////////////////////////////////////////

// reorder buffer slots and the credit pool of the front end
`define ROB_DEPTH 16

// every physical register not mapped at reset starts out free
`define FREE_DEPTH (`PHYS_REGS - `ARCH_REGS)

`endif

/* hw/rename_pkg.sv */
`include "rename_settings.svh"

package rename_pkg;

    // architectural register number r0 .. r31
    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;

    // physical register number p0 .. p63
    // p0 .. p31 hold the reset mapping
    // p32 .. p63 seed the free list
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_reg_t;

    // reorder buffer slot
    // also the tag that a completion carries back
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_index_t;

endpackage

/* hw/rob_pkg.sv */
package rob_pkg;

    import rename_pkg::*;

    ////////////////////////////////////////////////////////////////////////
    // reorder buffer entry
    ////////////////////////////////////////////////////////////////////////

    // one slot per dispatched instruction, written in order
    // and read back at retire
    typedef struct packed {
        logic      has_dest;   // instruction writes a register
        arch_reg_t dest_arch;  // architectural destination
        phys_reg_t new_pr;     // register given out at dispatch
        phys_reg_t old_pr;     // previous mapping, freed at retire
    } rob_entry_t;

endpackage

/* hw/ring_queue.sv */
`timescale 1ns/1ns

module ring_queue #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 16,
    localparam int IDX_W     = $clog2(DEPTH)
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             push,
    input  payload_t         push_data,
    input  logic             pop,
    output payload_t         head_data,
    output logic [IDX_W-1:0] tail_idx,
    output logic [IDX_W-1:0] head_idx,
    output logic             empty,
    output logic             full
);

    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DEPTH - 1);

    payload_t                 mem [DEPTH];  // entry storage
    logic [IDX_W-1:0]         head;         // oldest entry
    logic [IDX_W-1:0]         tail;         // next write slot
    logic [$clog2(DEPTH+1)-1:0] count;      // entries held

    ////////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push)
                tail <= (tail == LAST_IDX) ? '0 : tail + 1'b1;  // wrap at depth
            if (pop)
                head <= (head == LAST_IDX) ? '0 : head + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    // storage write
    always_ff @(posedge clock) begin
        if (push)
            mem[tail] <= push_data;
    end

    assign head_data = mem[head];  // first word fall through
    assign tail_idx  = tail;
    assign head_idx  = head;
    assign empty     = (count == 0);
    assign full      = (count == DEPTH);

    // overflow and underflow guards
    no_push_when_full : assert property (
        @(posedge clock) disable iff (reset) push |-> !full
    ) else $error("ring_queue: push into a full queue");

    no_pop_when_empty : assert property (
        @(posedge clock) disable iff (reset) pop |-> !empty
    ) else $error("ring_queue: pop from an empty queue");

endmodule

/* hw/init_counter.sv */
`timescale 1ns/1ns
`include "rename_settings.svh"

module init_counter
    import rename_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      enable,
    output phys_reg_t index,
    output logic      last
);

    localparam phys_reg_t FIRST_FREE = phys_reg_t'(`ARCH_REGS);      // first unmapped reg
    localparam phys_reg_t FINAL_FREE = phys_reg_t'(`PHYS_REGS - 1);  // top of the file

    phys_reg_t count;

    // walks p32 .. p63, one per enabled cycle
    always_ff @(posedge clock) begin
        if (reset)
            count <= FIRST_FREE;
        else if (enable && !last)
            count <= count + 1'b1;  // holds on the final index
    end

    assign index = count;
    assign last  = (count == FINAL_FREE);  // final push this cycle

endmodule

/* hw/rename_control.sv */
`timescale 1ns/1ns

module rename_control
    import rename_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      init_last,
    input  logic      retire_valid,
    input  logic      retire_has_dest,
    input  phys_reg_t retire_old_pr,
    input  phys_reg_t init_index,
    output logic      init_enable,
    output logic      fl_push,
    output phys_reg_t fl_push_data,
    output logic      ready,
    output logic      credit_return
);

    typedef enum logic {
        INIT,  // seeding the free list
        RUN    // dispatch open
    } state_t;

    state_t state;

    always_ff @(posedge clock) begin
        if (reset)
            state <= INIT;
        else if (state == INIT && init_last)
            state <= RUN;  // last seed pushed this edge
    end

    // free list push source
    // the counter in INIT and the retiring old register in RUN
    always_comb begin
        init_enable  = (state == INIT);
        fl_push      = (state == INIT) ? 1'b1 : (retire_valid && retire_has_dest);
        fl_push_data = (state == INIT) ? init_index : retire_old_pr;
    end

    assign ready         = (state == RUN);
    assign credit_return = (state == RUN) && retire_valid;  // one slot back per retire

    run_is_final : assert property (
        @(posedge clock) disable iff (reset) state == RUN |=> state == RUN
    ) else $error("rename_control: left RUN without reset");

    // buffer stays empty until dispatch opens
    no_retire_in_init : assert property (
        @(posedge clock) disable iff (reset) retire_valid |-> state == RUN
    ) else $error("rename_control: retire during init");

endmodule

/* hw/map_table.sv */
`timescale 1ns/1ns
`include "rename_settings.svh"

module map_table
    import rename_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      dispatch_valid,
    input  arch_reg_t src1_arch,
    input  arch_reg_t src2_arch,
    input  logic      has_dest,
    input  arch_reg_t dest_arch,
    input  phys_reg_t new_pr,
    output logic      rename_valid,
    output phys_reg_t src1_pr,
    output phys_reg_t src2_pr,
    output logic      src1_ready,
    output logic      src2_ready,
    output phys_reg_t dest_pr,
    output phys_reg_t old_pr,
    input  logic      set_ready_valid,
    input  phys_reg_t set_ready_pr
);

    phys_reg_t              map_q [`ARCH_REGS];  // speculative arch to phys map
    logic [`PHYS_REGS-1:0]  ready_q;             // value present per phys reg

    ////////////////////////////////////////////////////////////////////////
    // map and ready bits
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++)
                map_q[i] <= phys_reg_t'(i);  // identity mapping
            ready_q <= '1;                   // every value present
        end else begin
            if (set_ready_valid)
                ready_q[set_ready_pr] <= 1'b1;  // completion broadcast
            if (dispatch_valid && has_dest) begin
                map_q[dest_arch] <= new_pr;
                ready_q[new_pr]  <= 1'b0;       // not yet written
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // rename outputs one cycle after dispatch
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset)
            rename_valid <= 1'b0;
        else
            rename_valid <= dispatch_valid;
    end

    // lookups read the map before this dispatch's own write
    // ready bits are the pre-edge values with no completion bypass
    always_ff @(posedge clock) begin
        if (dispatch_valid) begin
            src1_pr    <= map_q[src1_arch];
            src2_pr    <= map_q[src2_arch];
            src1_ready <= ready_q[map_q[src1_arch]];
            src2_ready <= ready_q[map_q[src2_arch]];
            dest_pr    <= new_pr;
            old_pr     <= map_q[dest_arch];  // freed when this entry retires
        end
    end

endmodule

/* hw/reorder_buffer.sv */
`timescale 1ns/1ns
`include "rename_settings.svh"

module reorder_buffer
    import rename_pkg::*;
    import rob_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       dispatch_valid,
    input  logic       has_dest,
    input  arch_reg_t  dest_arch,
    input  phys_reg_t  new_pr,
    input  phys_reg_t  old_pr,
    output rob_index_t rob_idx,
    input  logic       complete_valid,
    input  rob_index_t complete_rob_idx,
    output logic       complete_pr_valid,
    output phys_reg_t  complete_pr,
    output logic       retire_valid,
    output logic       retire_has_dest,
    output arch_reg_t  retire_arch,
    output phys_reg_t  retire_new_pr,
    output phys_reg_t  retire_old_pr
);

    // dispatch fields wait one cycle for old_pr from the map
    logic       stage_valid;
    logic       stage_has_dest;
    arch_reg_t  stage_arch;
    phys_reg_t  stage_new_pr;
    rob_entry_t push_entry;
    rob_entry_t head_entry;
    rob_index_t tail_idx;
    rob_index_t head_idx;
    rob_index_t wr_slot;   // slot of the dispatch at this edge
    logic       empty;

    logic                  dest_valid_q [`ROB_DEPTH];  // side copy for completion lookup
    phys_reg_t             dest_pr_q    [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] done_q;

    assign wr_slot = tail_idx + rob_index_t'(stage_valid);  // skip a pending push

    always_ff @(posedge clock) begin
        if (reset)
            stage_valid <= 1'b0;
        else
            stage_valid <= dispatch_valid;
    end

    always_ff @(posedge clock) begin
        if (dispatch_valid) begin
            stage_has_dest        <= has_dest;
            stage_arch            <= dest_arch;
            stage_new_pr          <= new_pr;
            dest_valid_q[wr_slot] <= has_dest;
            dest_pr_q[wr_slot]    <= new_pr;
            rob_idx               <= wr_slot;  // shown with the rename outputs
        end
    end

    always_comb begin
        push_entry.has_dest  = stage_has_dest;
        push_entry.dest_arch = stage_arch;
        push_entry.new_pr    = stage_new_pr;
        push_entry.old_pr    = old_pr;  // registered by the map this cycle
    end

    ring_queue #(
        .payload_t (rob_entry_t),
        .DEPTH     (`ROB_DEPTH)
    ) entry_queue (
        .clock     (clock),
        .reset     (reset),
        .push      (stage_valid),
        .push_data (push_entry),
        .pop       (retire_valid),
        .head_data (head_entry),
        .tail_idx  (tail_idx),
        .head_idx  (head_idx),
        .empty     (empty),
        .full      ()
    );

    ////////////////////////////////////////////////////////////////////////
    // completion and retire
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            done_q <= '0;
        end else begin
            if (complete_valid)
                done_q[complete_rob_idx] <= 1'b1;
            if (retire_valid)
                done_q[head_idx] <= 1'b0;  // slot free for reuse
        end
    end

    assign complete_pr_valid = complete_valid && dest_valid_q[complete_rob_idx];
    assign complete_pr       = dest_pr_q[complete_rob_idx];

    assign retire_valid    = !empty && done_q[head_idx];  // in order, head only
    assign retire_has_dest = head_entry.has_dest;
    assign retire_arch     = head_entry.dest_arch;
    assign retire_new_pr   = head_entry.new_pr;
    assign retire_old_pr   = head_entry.old_pr;

    single_completion : assert property (
        @(posedge clock) disable iff (reset) complete_valid |-> !done_q[complete_rob_idx]
    ) else $error("reorder_buffer: completion of a slot already done");

endmodule

/* hw/rename_core.sv */
`timescale 1ns/1ns
`include "rename_settings.svh"

module rename_core
    import rename_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    output logic       ready,
    input  logic       dispatch_valid,
    input  arch_reg_t  src1_arch,
    input  arch_reg_t  src2_arch,
    input  logic       has_dest,
    input  arch_reg_t  dest_arch,
    output logic       rename_valid,
    output phys_reg_t  src1_pr,
    output phys_reg_t  src2_pr,
    output logic       src1_ready,
    output logic       src2_ready,
    output phys_reg_t  dest_pr,
    output phys_reg_t  old_pr,
    output rob_index_t rename_rob_idx,
    input  logic       complete_valid,
    input  rob_index_t complete_rob_idx,
    output logic       retire_valid,
    output logic       retire_has_dest,
    output arch_reg_t  retire_arch,
    output phys_reg_t  retire_new_pr,
    output phys_reg_t  retire_old_pr,
    output logic       credit_return
);

    logic      init_enable;
    logic      init_last;
    phys_reg_t init_index;
    logic      fl_push;
    phys_reg_t fl_push_data;
    logic      fl_pop;
    phys_reg_t fl_head;            // next register to hand out
    logic      complete_pr_valid;
    phys_reg_t complete_pr;

    assign fl_pop = dispatch_valid && has_dest;  // only writers consume a register

    ////////////////////////////////////////////////////////////////////////
    // control and free list
    ////////////////////////////////////////////////////////////////////////

    init_counter init_counter_i (
        .clock  (clock),
        .reset  (reset),
        .enable (init_enable),
        .index  (init_index),
        .last   (init_last)
    );

    rename_control rename_control_i (
        .clock           (clock),
        .reset           (reset),
        .init_last       (init_last),
        .retire_valid    (retire_valid),
        .retire_has_dest (retire_has_dest),
        .retire_old_pr   (retire_old_pr),
        .init_index      (init_index),
        .init_enable     (init_enable),
        .fl_push         (fl_push),
        .fl_push_data    (fl_push_data),
        .ready           (ready),
        .credit_return   (credit_return)
    );

    // twice the buffer depth so it never runs dry
    ring_queue #(
        .payload_t (phys_reg_t),
        .DEPTH     (`FREE_DEPTH)
    ) free_list_i (
        .clock     (clock),
        .reset     (reset),
        .push      (fl_push),
        .push_data (fl_push_data),
        .pop       (fl_pop),
        .head_data (fl_head),
        .tail_idx  (),
        .head_idx  (),
        .empty     (),
        .full      ()
    );

    ////////////////////////////////////////////////////////////////////////
    // rename and reorder
    ////////////////////////////////////////////////////////////////////////

    map_table map_table_i (
        .clock           (clock),
        .reset           (reset),
        .dispatch_valid  (dispatch_valid),
        .src1_arch       (src1_arch),
        .src2_arch       (src2_arch),
        .has_dest        (has_dest),
        .dest_arch       (dest_arch),
        .new_pr          (fl_head),
        .rename_valid    (rename_valid),
        .src1_pr         (src1_pr),
        .src2_pr         (src2_pr),
        .src1_ready      (src1_ready),
        .src2_ready      (src2_ready),
        .dest_pr         (dest_pr),
        .old_pr          (old_pr),
        .set_ready_valid (complete_pr_valid),
        .set_ready_pr    (complete_pr)
    );

    reorder_buffer reorder_buffer_i (
        .clock             (clock),
        .reset             (reset),
        .dispatch_valid    (dispatch_valid),
        .has_dest          (has_dest),
        .dest_arch         (dest_arch),
        .new_pr            (fl_head),
        .old_pr            (old_pr),
        .rob_idx           (rename_rob_idx),
        .complete_valid    (complete_valid),
        .complete_rob_idx  (complete_rob_idx),
        .complete_pr_valid (complete_pr_valid),
        .complete_pr       (complete_pr),
        .retire_valid      (retire_valid),
        .retire_has_dest   (retire_has_dest),
        .retire_arch       (retire_arch),
        .retire_new_pr     (retire_new_pr),
        .retire_old_pr     (retire_old_pr)
    );

endmodule

/* testbench/rename_checker.sv */
`timescale 1ns/1ns
`include "rename_settings.svh"

module rename_checker
    import rename_pkg::*;
    import rob_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       ready,
    input  logic       dispatch_valid,
    input  arch_reg_t  src1_arch,
    input  arch_reg_t  src2_arch,
    input  logic       has_dest,
    input  arch_reg_t  dest_arch,
    input  logic       rename_valid,
    input  phys_reg_t  src1_pr,
    input  phys_reg_t  src2_pr,
    input  logic       src1_ready,
    input  logic       src2_ready,
    input  phys_reg_t  dest_pr,
    input  phys_reg_t  old_pr,
    input  rob_index_t rename_rob_idx,
    input  logic       complete_valid,
    input  rob_index_t complete_rob_idx,
    input  logic       retire_valid,
    input  logic       retire_has_dest,
    input  arch_reg_t  retire_arch,
    input  phys_reg_t  retire_new_pr,
    input  phys_reg_t  retire_old_pr,
    input  logic       credit_return,
    output int         error_count,
    output int         check_count,
    output int         test_count
);

    ////////////////////////////////////////////////////////////////////////////
    // reference state
    ////////////////////////////////////////////////////////////////////////////

    phys_reg_t             map_m [`ARCH_REGS];  // speculative map
    logic [`PHYS_REGS-1:0] ready_m;
    phys_reg_t             free_m [$];          // head is the next allocation
    rob_entry_t            rob_m  [`ROB_DEPTH];
    logic                  busy_m [`ROB_DEPTH]; // dispatched, not retired
    logic                  done_m [`ROB_DEPTH];
    int                    rob_head;
    int                    rob_tail;
    int                    rob_count;
    int                    run_cycles;          // edges since reset fell
    logic                  retire_due;

    // rename outputs owed for the previous edge
    logic       exp_valid;
    phys_reg_t  exp_src1_pr;
    phys_reg_t  exp_src2_pr;
    logic       exp_src1_ready;
    logic       exp_src2_ready;
    rob_index_t exp_rob_idx;
    rob_entry_t exp_entry;

    int errors;
    int checks;
    int tests;
    int errors_mark;  // totals at the start of the current test
    int checks_mark;

    assign error_count = errors;
    assign check_count = checks;
    assign test_count  = tests;

    task automatic compare_field(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail %0t: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    task automatic report_error(input string text);
        errors++;
        $display("error at %0t: %s", $time, text);
    endtask

    // every physical register is either mapped or free, exactly once
    task automatic report_test(input string name);
        int uses [`PHYS_REGS];
        for (int p = 0; p < `PHYS_REGS; p++)
            uses[p] = 0;
        for (int a = 0; a < `ARCH_REGS; a++)
            uses[map_m[a]]++;
        for (int f = 0; f < free_m.size(); f++)
            uses[free_m[f]]++;
        for (int p = 0; p < `PHYS_REGS; p++)
            if (uses[p] != 1)
                report_error($sformatf("p%0d is held %0d times after the drain", p, uses[p]));
        if (rob_count != 0)
            report_error("reorder buffer still holds entries after the drain");
        tests++;
        $display("test %0d %s: %0d checks, %0d errors", tests, name,
                 checks - checks_mark, errors - errors_mark);
        errors_mark = errors;
        checks_mark = checks;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // per edge comparison on the values held before the edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_outputs();
        compare_field("ready", ready, run_cycles > `FREE_DEPTH);  // init length
        if (!ready && (retire_valid || credit_return))
            report_error("retire or credit return before the core was ready");
        if (dispatch_valid && !ready)
            report_error("dispatch before the core was ready");
        compare_field("rename_valid", rename_valid, exp_valid);
        if (exp_valid) begin
            compare_field("src1_pr", src1_pr, exp_src1_pr);
            compare_field("src2_pr", src2_pr, exp_src2_pr);
            compare_field("src1_ready", src1_ready, exp_src1_ready);
            compare_field("src2_ready", src2_ready, exp_src2_ready);
            compare_field("rename_rob_idx", rename_rob_idx, exp_rob_idx);
            if (exp_entry.has_dest) begin
                compare_field("dest_pr", dest_pr, exp_entry.new_pr);
                compare_field("old_pr", old_pr, exp_entry.old_pr);
            end
        end
        retire_due = (rob_count > 0) && done_m[rob_head];  // head only and in order
        compare_field("retire_valid", retire_valid, retire_due);
        compare_field("credit_return", credit_return, retire_due);
        if (retire_due && retire_valid) begin
            compare_field("retire_has_dest", retire_has_dest, rob_m[rob_head].has_dest);
            compare_field("retire_arch", retire_arch, rob_m[rob_head].dest_arch);
            if (rob_m[rob_head].has_dest) begin
                compare_field("retire_new_pr", retire_new_pr, rob_m[rob_head].new_pr);
                compare_field("retire_old_pr", retire_old_pr, rob_m[rob_head].old_pr);
            end
        end
    endtask

    task automatic advance_model();
        if (dispatch_valid) begin
            if (rob_count >= `ROB_DEPTH)
                report_error("dispatch while every reorder buffer slot was taken");
            exp_src1_pr         = map_m[src1_arch];
            exp_src2_pr         = map_m[src2_arch];
            exp_src1_ready      = ready_m[exp_src1_pr];  // no same edge bypass
            exp_src2_ready      = ready_m[exp_src2_pr];
            exp_rob_idx         = rob_index_t'(rob_tail);
            exp_entry.has_dest  = has_dest;
            exp_entry.dest_arch = dest_arch;
            exp_entry.old_pr    = map_m[dest_arch];
            exp_entry.new_pr    = '0;
            if (has_dest) begin
                exp_entry.new_pr          = free_m.pop_front();
                map_m[dest_arch]          = exp_entry.new_pr;
                ready_m[exp_entry.new_pr] = 1'b0;
            end
            rob_m[rob_tail]  = exp_entry;
            busy_m[rob_tail] = 1'b1;
            done_m[rob_tail] = 1'b0;
            rob_tail         = (rob_tail + 1) % `ROB_DEPTH;
            rob_count++;
        end
        exp_valid = dispatch_valid;
        if (complete_valid) begin
            if (!busy_m[complete_rob_idx] || done_m[complete_rob_idx]) begin
                report_error("completion names a slot that is not waiting");
            end else begin
                done_m[complete_rob_idx] = 1'b1;
                if (rob_m[complete_rob_idx].has_dest)
                    ready_m[rob_m[complete_rob_idx].new_pr] = 1'b1;
            end
        end
        if (retire_due) begin
            if (rob_m[rob_head].has_dest)
                free_m.push_back(rob_m[rob_head].old_pr);  // back of the free list
            busy_m[rob_head] = 1'b0;
            done_m[rob_head] = 1'b0;
            rob_head         = (rob_head + 1) % `ROB_DEPTH;
            rob_count--;
        end
    endtask

    always @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a < `ARCH_REGS; a++)
                map_m[a] = phys_reg_t'(a);  // identity
            ready_m = '1;
            free_m.delete();
            for (int p = `ARCH_REGS; p < `PHYS_REGS; p++)
                free_m.push_back(phys_reg_t'(p));  // init walk order
            for (int s = 0; s < `ROB_DEPTH; s++) begin
                busy_m[s] = 1'b0;
                done_m[s] = 1'b0;
            end
            rob_head   = 0;
            rob_tail   = 0;
            rob_count  = 0;
            run_cycles = 0;
            exp_valid  = 1'b0;
        end else begin
            run_cycles++;
            check_outputs();
            advance_model();
        end
    end

endmodule

/* testbench/rename_core_tb.sv */
`timescale 1ns/1ns
`include "rename_settings.svh"

module rename_core_tb
    import rename_pkg::*;
();

    localparam int CREDIT_IDLE   = 40;   // cycles held with the pool empty
    localparam int RANDOM_CYCLES = 300;
    localparam int RANDOM_TESTS  = 3;
    localparam int DRAIN_MARGIN  = 100;  // bound on one drain
    localparam int TIMEOUT_CYCLES = 2 + `FREE_DEPTH + `ROB_DEPTH + CREDIT_IDLE
                                    + RANDOM_TESTS * RANDOM_CYCLES
                                    + (RANDOM_TESTS + 1) * DRAIN_MARGIN + 100;

    logic       clock;
    logic       reset;
    logic       ready;
    logic       dispatch_valid;
    arch_reg_t  src1_arch;
    arch_reg_t  src2_arch;
    logic       has_dest;
    arch_reg_t  dest_arch;
    logic       rename_valid;
    phys_reg_t  src1_pr;
    phys_reg_t  src2_pr;
    logic       src1_ready;
    logic       src2_ready;
    phys_reg_t  dest_pr;
    phys_reg_t  old_pr;
    rob_index_t rename_rob_idx;
    logic       complete_valid;
    rob_index_t complete_rob_idx;
    logic       retire_valid;
    logic       retire_has_dest;
    arch_reg_t  retire_arch;
    phys_reg_t  retire_new_pr;
    phys_reg_t  retire_old_pr;
    logic       credit_return;

    int     error_count;
    int     check_count;
    int     test_count;
    integer seed;
    int     credits;       // front end view of free reorder buffer slots
    int     inflight [$];  // slots dispatched, not yet completed
    int     next_slot;
    int     cycle_count;

    rename_core rename_core_i (.*);

    rename_checker rename_checker_i (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // run limit from the test lengths
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: no end of run after %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic bit chance(input int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    function automatic int pick_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // one edge of front end and completion traffic
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_cycle(input int dispatch_pct, input int complete_pct,
                               input int reg_span);
        int pos;
        @(posedge clock);
        if (credit_return)
            credits++;                 // slot freed at this edge
        complete_valid <= 1'b0;
        // only slots dispatched at earlier edges can complete
        if (inflight.size() > 0 && chance(complete_pct)) begin
            pos = pick_below(inflight.size());
            complete_valid   <= 1'b1;
            complete_rob_idx <= rob_index_t'(inflight[pos]);
            inflight.delete(pos);
        end
        dispatch_valid <= 1'b0;
        src1_arch      <= arch_reg_t'(pick_below(reg_span));
        src2_arch      <= arch_reg_t'(pick_below(reg_span));
        dest_arch      <= arch_reg_t'(pick_below(reg_span));
        has_dest       <= chance(75);
        if (credits > 0 && chance(dispatch_pct)) begin
            credits--;
            dispatch_valid <= 1'b1;
            inflight.push_back(next_slot);
            next_slot = (next_slot + 1) % `ROB_DEPTH;
        end
    endtask

    // no new dispatch until every slot is back
    task automatic drain();
        while (credits < `ROB_DEPTH)
            drive_cycle(0, 60, `ARCH_REGS);
    endtask

    task automatic end_test(input string name);
        @(negedge clock);                       // model settled for this edge
        rename_checker_i.report_test(name);
    endtask

    task automatic run_random(input string name, input int dispatch_pct,
                              input int complete_pct, input int reg_span);
        repeat (RANDOM_CYCLES)
            drive_cycle(dispatch_pct, complete_pct, reg_span);
        drain();
        end_test(name);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        seed             = 32'h3db8;
        reset            = 1'b1;
        dispatch_valid   = 1'b0;
        src1_arch        = '0;
        src2_arch        = '0;
        has_dest         = 1'b0;
        dest_arch        = '0;
        complete_valid   = 1'b0;
        complete_rob_idx = '0;
        credits          = 0;
        next_slot        = 0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        while (!ready)
            @(posedge clock);                   // free list fill
        credits = `ROB_DEPTH;
        end_test("init");

        // nothing completes, so the pool runs dry and stays dry
        repeat (`ROB_DEPTH + CREDIT_IDLE)
            drive_cycle(100, 0, `ARCH_REGS);
        @(negedge clock);
        if (credits != 0 || inflight.size() != `ROB_DEPTH)
            rename_checker_i.report_error("front end did not stall after a full buffer");
        drain();
        end_test("credit_limit");

        run_random("random_mix", 70, 50, `ARCH_REGS);
        run_random("tight_deps", 80, 40, 4);     // few registers, long chains
        run_random("slow_complete", 90, 15, 8);  // pool mostly empty

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

/* rename_core.f */
+incdir+hw
hw/rename_pkg.sv
hw/rob_pkg.sv
hw/ring_queue.sv
hw/init_counter.sv
hw/rename_control.sv
hw/map_table.sv
hw/reorder_buffer.sv
hw/rename_core.sv
testbench/rename_checker.sv
testbench/rename_core_tb.sv
